// ==== design/soc_pkg.sv ====
`default_nettype none

package soc_pkg;

    // --------------------------------------------------
    // Bus geometry
    // --------------------------------------------------
    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 32;
    localparam int BE_WIDTH   = 4;

    // Region codes, matched against address bits 31:24
    localparam logic [7:0] REGION_RAM   = 8'h00;
    localparam logic [7:0] REGION_FLASH = 8'h02;
    localparam logic [7:0] REGION_UART  = 8'h0A;
    localparam logic [7:0] REGION_LED   = 8'h0F;

    // Byte address width, so 1024 words
    localparam int RAM_ADDR_WIDTH = 12;

    // --------------------------------------------------
    // Serial peripherals
    // --------------------------------------------------
    localparam int UART_DIV = 8;
    // Half period of sck
    localparam int SPI_DIV  = 2;

    localparam logic [7:0] FLASH_READ_CMD   = 8'h03;
    localparam int         FLASH_ADDR_WIDTH = 24;

    localparam logic LED_RESET = 1'b1;

endpackage

`default_nettype wire

// ==== design/bit_timer.sv ====
`timescale 1ns/100ps
`default_nettype none

module bit_timer #(
    parameter int DIV = 2
) (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic run_i,
    output logic tick_o
);
    localparam int CW = (DIV > 1) ? $clog2(DIV) : 1;
    localparam logic [CW-1:0] LAST = CW'(DIV - 1);

    logic [CW-1:0] cnt_q;

    // Tick on the last cycle of each period
    assign tick_o = run_i && (cnt_q == LAST);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cnt_q <= '0;
        end else if (!run_i) begin
            // Idle, so the next frame gets a full first period
            cnt_q <= '0;
        end else if (cnt_q == LAST) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== design/soc_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module soc_ram (
    input  logic                                clk_i,
    input  logic                                en_i,
    input  logic                                we_i,
    input  logic [soc_pkg::BE_WIDTH-1:0]        be_i,
    input  logic [soc_pkg::RAM_ADDR_WIDTH-3:0]  addr_i,
    input  logic [soc_pkg::DATA_WIDTH-1:0]      wdata_i,
    output logic [soc_pkg::DATA_WIDTH-1:0]      rdata_o
);
    import soc_pkg::*;

    localparam int WORDS = 2 ** (RAM_ADDR_WIDTH - 2);

    logic [DATA_WIDTH-1:0] mem [WORDS];

    // Read returns the word as it was before any write in the same cycle
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            rdata_o <= mem[addr_i];
            if (we_i) begin
                for (int b = 0; b < BE_WIDTH; b++) begin
                    if (be_i[b]) begin
                        mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/spi_flash_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module spi_flash_ctrl (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,
    input  logic                                 start_i,
    input  logic [soc_pkg::FLASH_ADDR_WIDTH-1:0] addr_i,
    output logic [soc_pkg::DATA_WIDTH-1:0]       rdata_o,
    output logic                                 done_o,
    output logic                                 sck_o,
    output logic                                 sdo_o,
    input  logic                                 sdi_i,
    output logic                                 cs_no
);
    import soc_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SHIFT_OUT,
        ST_SHIFT_IN,
        ST_FINISH
    } state_e;

    state_e                state_q;
    logic [4:0]            bit_cnt_q;
    logic                  sck_q;
    logic                  cs_n_q;
    logic                  run;
    logic                  tick;
    logic [31:0]           out_sr_q;
    logic [DATA_WIDTH-1:0] in_sr_q;

    assign run = (state_q == ST_SHIFT_OUT) || (state_q == ST_SHIFT_IN);

    bit_timer #(
        .DIV (SPI_DIV)
    ) u_half_period (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .run_i  (run),
        .tick_o (tick)
    );

    // --------------------------------------------------
    // Command, address and data phases
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= ST_IDLE;
            bit_cnt_q <= '0;
            sck_q     <= 1'b0;
            cs_n_q    <= 1'b1;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (start_i) begin
                        cs_n_q    <= 1'b0;
                        bit_cnt_q <= '0;
                        state_q   <= ST_SHIFT_OUT;
                    end
                end
                ST_SHIFT_OUT, ST_SHIFT_IN: begin
                    if (tick) begin
                        sck_q <= !sck_q;
                        // A full clock period ends on the falling edge
                        if (sck_q) begin
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                            if (bit_cnt_q == 5'd31) begin
                                state_q <= (state_q == ST_SHIFT_OUT) ? ST_SHIFT_IN
                                                                     : ST_FINISH;
                            end
                        end
                    end
                end
                ST_FINISH: begin
                    cs_n_q  <= 1'b1;
                    state_q <= ST_IDLE;
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Command out and data in, one bit per sck period
    always_ff @(posedge clk_i) begin
        if (state_q == ST_IDLE && start_i) begin
            out_sr_q <= {FLASH_READ_CMD, addr_i};
        end else if (state_q == ST_SHIFT_OUT && tick && sck_q) begin
            out_sr_q <= {out_sr_q[30:0], 1'b0};
        end

        // Sample on the rising edge of sck
        if (state_q == ST_SHIFT_IN && tick && !sck_q) begin
            in_sr_q <= {in_sr_q[DATA_WIDTH-2:0], sdi_i};
        end
    end

    assign sck_o  = sck_q;
    assign cs_no  = cs_n_q;
    assign sdo_o  = out_sr_q[31];
    assign done_o = state_q == ST_FINISH;

    // First byte on the wire lands in bits 7:0
    assign rdata_o = {in_sr_q[7:0], in_sr_q[15:8], in_sr_q[23:16], in_sr_q[31:24]};

    sck_idle_low: assert property (@(posedge clk_i) disable iff (!rst_ni)
        cs_no |-> !sck_o);

endmodule

`default_nettype wire

// ==== design/uart_tx.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_tx (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       we_i,
    input  logic [7:0] data_i,
    output logic       tx_o,
    output logic       busy_o
);
    import soc_pkg::*;

    logic       busy_q;
    logic       tick;
    logic [3:0] bit_cnt_q;
    logic [9:0] frame_q;

    bit_timer #(
        .DIV (UART_DIV)
    ) u_baud (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .run_i  (busy_q),
        .tick_o (tick)
    );

    // Frame is stop, data LSB first, start, sent from bit 0
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q    <= 1'b0;
            bit_cnt_q <= '0;
            frame_q   <= '1;
        end else if (!busy_q) begin
            if (we_i) begin
                frame_q   <= {1'b1, data_i, 1'b0};
                bit_cnt_q <= '0;
                busy_q    <= 1'b1;
            end
        end else if (tick) begin
            frame_q   <= {1'b1, frame_q[9:1]};
            bit_cnt_q <= bit_cnt_q + 1'b1;
            // End of the stop bit
            if (bit_cnt_q == 4'd9) begin
                busy_q <= 1'b0;
            end
        end
    end

    assign tx_o   = frame_q[0];
    assign busy_o = busy_q;

    // The interconnect must hold data writes back while a frame is on the line
    no_write_while_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
        we_i |-> !busy_o);

endmodule

`default_nettype wire

// ==== design/soc_interconnect.sv ====
`timescale 1ns/100ps
`default_nettype none

module soc_interconnect (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            req_i,
    output logic                            gnt_o,
    input  logic [soc_pkg::ADDR_WIDTH-1:0]  addr_i,
    input  logic                            we_i,
    input  logic [soc_pkg::BE_WIDTH-1:0]    be_i,
    input  logic [soc_pkg::DATA_WIDTH-1:0]  wdata_i,
    output logic                            rvalid_o,
    output logic [soc_pkg::DATA_WIDTH-1:0]  rdata_o,
    output logic                            ram_en_o,
    input  logic [soc_pkg::DATA_WIDTH-1:0]  ram_rdata_i,
    output logic                            flash_start_o,
    output logic [soc_pkg::FLASH_ADDR_WIDTH-1:0] flash_addr_o,
    input  logic [soc_pkg::DATA_WIDTH-1:0]  flash_rdata_i,
    input  logic                            flash_done_i,
    output logic                            uart_we_o,
    output logic [7:0]                      uart_data_o,
    input  logic                            uart_busy_i,
    output logic                            led_o
);
    import soc_pkg::*;

    logic [7:0]            region;
    logic                  sel_ram;
    logic                  sel_flash;
    logic                  sel_uart;
    logic                  sel_led;
    logic                  uart_busy_sel;
    logic                  uart_wr;
    logic                  flash_rd;
    logic                  stall;
    logic                  accept;
    logic [DATA_WIDTH-1:0] reg_rdata;

    logic                  rsp_valid_q;
    logic                  rsp_ram_q;
    logic [DATA_WIDTH-1:0] rsp_reg_q;
    logic                  flash_pend_q;
    logic                  flash_rsp_q;
    logic [DATA_WIDTH-1:0] flash_word_q;
    logic                  led_q;
    logic [1:0]            out_cnt_q;

    // --------------------------------------------------
    // Decode and grant
    // --------------------------------------------------
    assign region    = addr_i[ADDR_WIDTH-1 -: 8];
    assign sel_ram   = region == REGION_RAM;
    assign sel_flash = region == REGION_FLASH;
    assign sel_uart  = region == REGION_UART;
    assign sel_led   = region == REGION_LED;

    // Offset 4 holds the busy flag, offset 0 the data register
    assign uart_busy_sel = addr_i[2];
    assign uart_wr       = sel_uart && we_i && !uart_busy_sel;
    assign flash_rd      = sel_flash && !we_i;

    // Hold off everything behind a flash read, and UART data while sending
    assign stall  = flash_pend_q || (uart_wr && uart_busy_i);
    assign gnt_o  = req_i && !stall;
    assign accept = req_i && gnt_o;

    assign ram_en_o      = accept && sel_ram;
    assign flash_start_o = accept && flash_rd;
    assign flash_addr_o  = addr_i[FLASH_ADDR_WIDTH-1:0];
    assign uart_we_o     = accept && uart_wr;
    assign uart_data_o   = wdata_i[7:0];
    assign led_o         = led_q;

    // Small registers read back through bit 0, unmapped reads give zero
    always_comb begin
        reg_rdata = '0;
        if (sel_led) begin
            reg_rdata[0] = led_q;
        end else if (sel_uart && uart_busy_sel) begin
            reg_rdata[0] = uart_busy_i;
        end
    end

    // --------------------------------------------------
    // Response tracking
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rsp_valid_q  <= 1'b0;
            rsp_ram_q    <= 1'b0;
            flash_pend_q <= 1'b0;
            flash_rsp_q  <= 1'b0;
            led_q        <= LED_RESET;
            out_cnt_q    <= '0;
        end else begin
            rsp_valid_q <= accept && !flash_rd;
            rsp_ram_q   <= accept && sel_ram;
            flash_rsp_q <= flash_done_i && flash_pend_q;

            // Accepted accesses still waiting for their response
            out_cnt_q <= out_cnt_q + 2'(accept) - 2'(rvalid_o);

            if (flash_start_o) begin
                flash_pend_q <= 1'b1;
            end else if (flash_done_i) begin
                flash_pend_q <= 1'b0;
            end

            if (accept && sel_led && we_i && be_i[0]) begin
                led_q <= wdata_i[0];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            rsp_reg_q <= reg_rdata;
        end
        if (flash_done_i) begin
            flash_word_q <= flash_rdata_i;
        end
    end

    assign rvalid_o = rsp_valid_q || flash_rsp_q;

    always_comb begin
        if (flash_rsp_q) begin
            rdata_o = flash_word_q;
        end else if (rsp_ram_q) begin
            rdata_o = ram_rdata_i;
        end else begin
            rdata_o = rsp_reg_q;
        end
    end

    // Every response answers an access that was accepted earlier
    rvalid_has_source: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rvalid_o |-> out_cnt_q != 2'd0);

    // No flash start while an earlier access still waits beyond this cycle
    flash_start_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flash_start_o |-> (out_cnt_q == 2'd0) || (out_cnt_q == 2'd1 && rvalid_o));

endmodule

`default_nettype wire

// ==== design/soc_periph_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module soc_periph_top (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            req_i,
    output logic                            gnt_o,
    input  logic [soc_pkg::ADDR_WIDTH-1:0]  addr_i,
    input  logic                            we_i,
    input  logic [soc_pkg::BE_WIDTH-1:0]    be_i,
    input  logic [soc_pkg::DATA_WIDTH-1:0]  wdata_i,
    output logic                            rvalid_o,
    output logic [soc_pkg::DATA_WIDTH-1:0]  rdata_o,
    output logic                            led_o,
    output logic                            ser_tx_o,
    output logic                            sck_o,
    output logic                            sdo_o,
    input  logic                            sdi_i,
    output logic                            cs_no
);
    import soc_pkg::*;

    logic                        ram_en;
    logic [DATA_WIDTH-1:0]       ram_rdata;
    logic                        flash_start;
    logic [FLASH_ADDR_WIDTH-1:0] flash_addr;
    logic [DATA_WIDTH-1:0]       flash_rdata;
    logic                        flash_done;
    logic                        uart_we;
    logic [7:0]                  uart_data;
    logic                        uart_busy;

    soc_interconnect u_interconnect (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .req_i         (req_i),
        .gnt_o         (gnt_o),
        .addr_i        (addr_i),
        .we_i          (we_i),
        .be_i          (be_i),
        .wdata_i       (wdata_i),
        .rvalid_o      (rvalid_o),
        .rdata_o       (rdata_o),
        .ram_en_o      (ram_en),
        .ram_rdata_i   (ram_rdata),
        .flash_start_o (flash_start),
        .flash_addr_o  (flash_addr),
        .flash_rdata_i (flash_rdata),
        .flash_done_i  (flash_done),
        .uart_we_o     (uart_we),
        .uart_data_o   (uart_data),
        .uart_busy_i   (uart_busy),
        .led_o         (led_o)
    );

    // Word address straight from the bus
    soc_ram u_ram (
        .clk_i   (clk_i),
        .en_i    (ram_en),
        .we_i    (we_i),
        .be_i    (be_i),
        .addr_i  (addr_i[RAM_ADDR_WIDTH-1:2]),
        .wdata_i (wdata_i),
        .rdata_o (ram_rdata)
    );

    spi_flash_ctrl u_flash (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .start_i (flash_start),
        .addr_i  (flash_addr),
        .rdata_o (flash_rdata),
        .done_o  (flash_done),
        .sck_o   (sck_o),
        .sdo_o   (sdo_o),
        .sdi_i   (sdi_i),
        .cs_no   (cs_no)
    );

    uart_tx u_uart (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .we_i   (uart_we),
        .data_i (uart_data),
        .tx_o   (ser_tx_o),
        .busy_o (uart_busy)
    );

endmodule

`default_nettype wire

// ==== sim/spi_flash_model.sv ====
`timescale 1ns/100ps
`default_nettype none

module spi_flash_model (
    input  logic sck_i,
    input  logic cs_ni,
    input  logic mosi_i,
    output logic miso_o
);
    localparam logic [7:0] READ_CMD = 8'h03;

    logic [6:0]  bit_cnt;
    logic [31:0] cmd_addr;
    logic [6:0]  data_bit;
    logic [7:0]  cur_byte;

    // --------------------------------------------------
    // Command and address capture on rising sck
    // --------------------------------------------------
    always @(posedge sck_i or posedge cs_ni) begin
        if (cs_ni) begin
            bit_cnt <= '0;
        end else begin
            if (bit_cnt < 7'd32) begin
                cmd_addr <= {cmd_addr[30:0], mosi_i};
            end
            bit_cnt <= bit_cnt + 7'd1;
        end
    end

    // Byte for address a is a XOR 0xA5, address counts up per byte
    assign data_bit = bit_cnt - 7'd32;
    assign cur_byte = (cmd_addr[7:0] + {5'b0, data_bit[5:3]}) ^ 8'hA5;

    // Data changes on falling sck, MSB first
    always @(negedge sck_i or posedge cs_ni) begin
        if (cs_ni) begin
            miso_o <= 1'b0;
        end else if (bit_cnt >= 7'd32) begin
            if (cmd_addr[31:24] == READ_CMD) begin
                miso_o <= cur_byte[3'd7 - data_bit[2:0]];
            end else begin
                // Unknown command reads as zero
                miso_o <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_soc_periph.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_soc_periph;
    import soc_pkg::*;

    localparam int OP_READ  = 0;
    localparam int OP_WRITE = 1;
    localparam int OP_UART  = 2;
    localparam int OP_PAIR  = 3;
    localparam int OP_FLASH = 4;
    localparam int OP_TXEND = 5;
    localparam int OP_LED   = 6;
    localparam int LONGEST     = 64 * 2 * SPI_DIV + 100;
    localparam int GRANT_LIMIT = LONGEST;

    logic                  clk_i = 1'b0;
    logic                  rst_ni;
    logic                  req_i;
    logic                  gnt_o;
    logic [ADDR_WIDTH-1:0] addr_i;
    logic                  we_i;
    logic [BE_WIDTH-1:0]   be_i;
    logic [DATA_WIDTH-1:0] wdata_i;
    logic                  rvalid_o;
    logic [DATA_WIDTH-1:0] rdata_o;
    logic                  led_o;
    logic                  ser_tx_o;
    logic                  sck_o;
    logic                  sdo_o;
    logic                  sdi_i;
    logic                  cs_no;

    // Stimulus table, one entry per index
    string                 t_name[$];
    int                    t_op[$];
    logic [ADDR_WIDTH-1:0] t_addr[$];
    logic [DATA_WIDTH-1:0] t_wdata[$];
    logic [BE_WIDTH-1:0]   t_be[$];
    logic [DATA_WIDTH-1:0] t_exp[$];

    logic [7:0] tx_exp[$];
    logic [7:0] rx_q[$];
    int         cycle_cnt = 0;
    int         cycle_limit = 100000;

    soc_periph_top UUT (
        .clk_i, .rst_ni, .req_i, .gnt_o, .addr_i, .we_i, .be_i, .wdata_i,
        .rvalid_o, .rdata_o, .led_o, .ser_tx_o, .sck_o, .sdo_o, .sdi_i, .cs_no
    );

    spi_flash_model u_flash_model (
        .sck_i  (sck_o),
        .cs_ni  (cs_no),
        .mosi_i (sdo_o),
        .miso_o (sdi_i)
    );

    always #2 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("Timeout after %0d cycles, the run did not finish", cycle_cnt);
            $display("*** TEST FAILED ***");
            $fatal(1, "timeout");
        end
    end

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    task automatic stop_run(string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped on first error");
    endtask

    task automatic compare_word(string name, logic [DATA_WIDTH-1:0] exp,
                                logic [DATA_WIDTH-1:0] act);
        if (exp !== act) begin
            $display("FAILED %s expected %08h actual %08h", name, exp, act);
            $display("*** TEST FAILED ***");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic compare_byte(string name, logic [7:0] exp, logic [7:0] act);
        if (exp !== act) begin
            $display("FAILED %s expected %02h actual %02h", name, exp, act);
            $display("*** TEST FAILED ***");
            $fatal(1, "byte mismatch");
        end
    endtask

    // Flash word at byte offset o, first byte in bits 7:0
    function automatic logic [DATA_WIDTH-1:0] flash_word(int o);
        logic [DATA_WIDTH-1:0] w;
        for (int i = 0; i < 4; i++) begin
            w[8*i +: 8] = 8'(o + i) ^ 8'hA5;
        end
        return w;
    endfunction

    task automatic add_test(string name, int op, logic [ADDR_WIDTH-1:0] addr,
                            logic [DATA_WIDTH-1:0] wdata, logic [BE_WIDTH-1:0] be,
                            logic [DATA_WIDTH-1:0] exp);
        t_name.push_back(name);
        t_op.push_back(op);
        t_addr.push_back(addr);
        t_wdata.push_back(wdata);
        t_be.push_back(be);
        t_exp.push_back(exp);
    endtask

    // --------------------------------------------------
    // Bus driver, positioned on falling edges
    // --------------------------------------------------
    task automatic present(logic we, logic [ADDR_WIDTH-1:0] addr,
                           logic [DATA_WIDTH-1:0] data, logic [BE_WIDTH-1:0] be);
        @(posedge clk_i);
        req_i   <= 1'b1;
        we_i    <= we;
        addr_i  <= addr;
        wdata_i <= data;
        be_i    <= be;
        @(negedge clk_i);
    endtask

    task automatic wait_grant();
        int n = 0;
        while (!gnt_o) begin
            @(negedge clk_i);
            n++;
            if (n > GRANT_LIMIT) stop_run("A request was never granted");
        end
    endtask

    task automatic release_req();
        @(posedge clk_i);
        req_i <= 1'b0;
        @(negedge clk_i);
    endtask

    task automatic take_response(string name, logic [DATA_WIDTH-1:0] exp, bit check,
                                 int limit);
        int n = 0;
        while (!rvalid_o) begin
            @(negedge clk_i);
            n++;
            if (n > limit) stop_run({"No rvalid_o in time for ", name});
        end
        if (check) compare_word(name, exp, rdata_o);
    endtask

    // Samples each bit in its middle
    initial begin
        logic [7:0] data;
        wait (rst_ni === 1'b1);
        forever begin
            @(negedge ser_tx_o);
            repeat (UART_DIV / 2) @(negedge clk_i);
            if (ser_tx_o !== 1'b0) stop_run("UART start bit was too short");
            for (int i = 0; i < 8; i++) begin
                repeat (UART_DIV) @(negedge clk_i);
                data[i] = ser_tx_o;
            end
            repeat (UART_DIV) @(negedge clk_i);
            if (ser_tx_o !== 1'b1) stop_run("UART stop bit is missing");
            repeat (UART_DIV / 2) @(negedge clk_i);
            rx_q.push_back(data);
        end
    end

    task automatic run_entry(int k);
        int n = 0;
        case (t_op[k])
            OP_READ, OP_WRITE: begin
                present(t_op[k] == OP_WRITE, t_addr[k], t_wdata[k], t_be[k]);
                wait_grant();
                release_req();
                take_response(t_name[k], t_exp[k], t_op[k] == OP_READ, 0);
            end
            OP_PAIR: begin
                present(1'b0, t_addr[k], '0, '1);
                wait_grant();
                @(posedge clk_i);
                addr_i <= t_addr[k] + 32'd4;
                @(negedge clk_i);
                if (!gnt_o) stop_run("Second back-to-back read was not granted at once");
                take_response(t_name[k], t_exp[k], 1'b1, 0);
                release_req();
                take_response({t_name[k], " second"}, t_wdata[k], 1'b1, 0);
            end
            OP_FLASH: begin
                present(1'b0, t_addr[k], '0, '1);
                wait_grant();
                // Unmapped probe issued while the flash read is outstanding
                @(posedge clk_i);
                addr_i <= 32'h3000_0000;
                @(negedge clk_i);
                while (!rvalid_o) begin
                    if (gnt_o) stop_run("A request was granted during a flash read");
                    @(negedge clk_i);
                    n++;
                    if (n > LONGEST) stop_run("The flash read got no rvalid_o");
                end
                compare_word(t_name[k], t_exp[k], rdata_o);
                wait_grant();
                release_req();
                take_response({t_name[k], " probe"}, '0, 1'b1, 0);
            end
            OP_UART: begin
                present(1'b1, t_addr[k], {24'b0, t_wdata[k][7:0]}, '1);
                wait_grant();
                @(posedge clk_i);
                wdata_i <= {24'b0, t_wdata[k][15:8]};
                @(negedge clk_i);
                take_response(t_name[k], '0, 1'b0, 0);
                if (gnt_o) stop_run("Second UART write was not stalled while busy");
                wait_grant();
                release_req();
                take_response(t_name[k], '0, 1'b0, 0);
                tx_exp.push_back(t_wdata[k][7:0]);
                tx_exp.push_back(t_wdata[k][15:8]);
            end
            OP_TXEND: begin
                while (rx_q.size() < tx_exp.size()) begin
                    @(negedge clk_i);
                    n++;
                    if (n > LONGEST) stop_run("A UART frame never arrived");
                end
                while (tx_exp.size() > 0) begin
                    compare_byte(t_name[k], tx_exp.pop_front(), rx_q.pop_front());
                end
                repeat (UART_DIV) @(negedge clk_i);
            end
            OP_LED: compare_word(t_name[k], t_exp[k], {31'b0, led_o});
            default: stop_run("Unknown operation in the test table");
        endcase
    endtask

    initial begin
        rst_ni  = 1'b0;
        req_i   = 1'b0;
        we_i    = 1'b0;
        addr_i  = '0;
        be_i    = '0;
        wdata_i = '0;

        add_test("ram_wr0", OP_WRITE, 32'h0000_0010, 32'h1234_5678, 4'hF, '0);
        add_test("ram_wr1", OP_WRITE, 32'h0000_0014, 32'hCAFE_BABE, 4'hF, '0);
        add_test("ram_rd0", OP_READ, 32'h0000_0010, '0, 4'hF, 32'h1234_5678);
        add_test("ram_rd1", OP_READ, 32'h0000_0014, '0, 4'hF, 32'hCAFE_BABE);
        add_test("ram_be0", OP_WRITE, 32'h0000_0010, 32'hAABB_CCDD, 4'b0101, '0);
        add_test("ram_be1", OP_WRITE, 32'h0000_0014, 32'h1122_3344, 4'b1100, '0);
        add_test("ram_merge0", OP_READ, 32'h0000_0010, '0, 4'hF, 32'h12BB_56DD);
        add_test("ram_merge1", OP_READ, 32'h0000_0014, '0, 4'hF, 32'h1122_BABE);
        add_test("ram_b2b", OP_PAIR, 32'h0000_0010, 32'h1122_BABE, 4'hF, 32'h12BB_56DD);
        add_test("led_reset", OP_READ, 32'h0F00_0000, '0, 4'hF, {31'b0, LED_RESET});
        add_test("led_wr", OP_WRITE, 32'h0F00_0000, 32'h0, 4'h1, '0);
        add_test("led_pin", OP_LED, '0, '0, '0, 32'h0);
        add_test("led_rd", OP_READ, 32'h0F00_0000, '0, 4'hF, 32'h0);
        add_test("flash_5", OP_FLASH, 32'h0200_0005, '0, 4'hF, flash_word(5));
        add_test("flash_100", OP_FLASH, 32'h0200_0100, '0, 4'hF, flash_word(256));
        add_test("uart_send", OP_UART, 32'h0A00_0000, 32'h0000_5A3C, 4'hF, '0);
        add_test("uart_busy", OP_READ, 32'h0A00_0004, '0, 4'hF, 32'h1);
        add_test("uart_bytes", OP_TXEND, '0, '0, '0, '0);
        add_test("uart_idle", OP_READ, 32'h0A00_0004, '0, 4'hF, 32'h0);
        add_test("unmap_wr", OP_WRITE, 32'h3000_0010, 32'hFFFF_FFFF, 4'hF, '0);
        add_test("unmap_rd", OP_READ, 32'h3000_0010, '0, 4'hF, 32'h0);
        add_test("ram_kept", OP_READ, 32'h0000_0010, '0, 4'hF, 32'h12BB_56DD);
        cycle_limit = 16 + t_name.size() * LONGEST;

        repeat (16) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        compare_word("reset_gnt", 32'h0, {31'b0, gnt_o});
        compare_word("reset_rvalid", 32'h0, {31'b0, rvalid_o});
        compare_word("reset_cs", 32'h1, {31'b0, cs_no});
        compare_word("reset_sck", 32'h0, {31'b0, sck_o});
        compare_word("reset_tx", 32'h1, {31'b0, ser_tx_o});
        compare_word("reset_led", {31'b0, LED_RESET}, {31'b0, led_o});

        for (int k = 0; k < t_name.size(); k++) begin
            run_entry(k);
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
design/soc_pkg.sv
design/bit_timer.sv
design/soc_ram.sv
design/spi_flash_ctrl.sv
design/uart_tx.sv
design/soc_interconnect.sv
design/soc_periph_top.sv
sim/spi_flash_model.sv
sim/tb_soc_periph.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_soc_periph -f flist.f \
    --Mdir obj_dir -o tb_sim > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1

grep -q '\*\*\* TEST PASSED \*\*\*' sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
